// File: source/pipeStage.sv
/*
	Pipeline register for any payload with a valid field.
	Loads every cycle unless held; flush or reset empties the slot.
*/
`timescale 1ns/1ps
`default_nettype none

module pipeStage import renamePkg::*; #(
	parameter type payloadT = decodedInstr
) (
	input logic clk,
	input logic reset,
	input logic hold,
	input logic flush,
	input payloadT d,
	output payloadT q
);

	always_ff @(posedge clk) begin
		if (!hold) begin
			q <= d; // Advance the payload.
		end
		// Only the valid bit is cleared; the stale payload does no harm.
		if (reset || flush) begin
			q.valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: source/regStatusTable.sv
/*
	Register status table holding a busy bit and the newest ROB tag for every register.
	Renames the held instruction, frees registers on commit, reloads on restore.
*/
`timescale 1ns/1ps
`default_nettype none
`include "rename_defs.svh"

module regStatusTable import renamePkg::*; (
	input logic clk,
	input logic reset,
	input decodedInstr instr,
	input logic allocate,
	input logic [`ROB_W-1:0] tailTag,
	input commitInfo commitIn,
	input logic restore,
	input statusSnap restoreSnap,
	output renamedInstr renamed,
	output logic [`NUM_REGS-1:0] busyVector
);

	logic [`NUM_REGS-1:0] busy; // One bit per architectural register.
	logic [`NUM_REGS-1:0] busyNext;
	logic [`ROB_W-1:0] robTags [`NUM_REGS]; // Newest producer of each register.
	logic freeHit; // Commit frees its rd this cycle.
	logic src1Busy;
	logic src2Busy;

	// ==================================================
	// Commit match
	// ==================================================
	// A younger writer has overwritten the tag, so an older commit leaves it alone.
	always_comb begin
		freeHit = commitIn.valid && busy[commitIn.rd]
			&& (robTags[commitIn.rd] == commitIn.robTag);
	end

	// ==================================================
	// Rename lookup
	// ==================================================
	always_comb begin
		// A source freed by this cycle's commit bypasses straight to ready.
		src1Busy = busy[instr.rs1] && !(freeHit && (commitIn.rd == instr.rs1));
		src2Busy = busy[instr.rs2] && !(freeHit && (commitIn.rd == instr.rs2));

		renamed.valid = instr.valid;
		renamed.rs1Tag.busy = src1Busy;
		renamed.rs1Tag.robTag = src1Busy ? robTags[instr.rs1] : '0; // Zero when ready.
		renamed.rs2Tag.busy = src2Busy;
		renamed.rs2Tag.robTag = src2Busy ? robTags[instr.rs2] : '0;
		renamed.rdValid = allocate; // Control already checked regWrite, rd and space.
		renamed.destTag = allocate ? tailTag : '0;
	end

	// ==================================================
	// Busy vector update
	// ==================================================
	always_comb begin
		busyNext = busy;
		if (freeHit) begin
			busyNext[commitIn.rd] = 1'b0; // Oldest writer retires.
		end
		if (allocate) begin
			busyNext[instr.rd] = 1'b1; // New writer wins over a same-cycle commit.
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= '0;
		end else if (restore) begin
			busy <= restoreSnap.busyVector; // Back to the checkpoint.
		end else begin
			busy <= busyNext;
		end
	end

	// Each register remembers the ROB entry that will produce its value.
	always_ff @(posedge clk) begin
		if (allocate) begin
			robTags[instr.rd] <= tailTag;
		end
	end

	assign busyVector = busy;

	// x0 must stay free through rename, commit and restore alike.
	assert property (@(posedge clk) disable iff (reset) !busy[0])
		else $error("Register x0 became busy.");

endmodule

`default_nettype wire

// File: source/renameControl.sv
/*
	Rename stage control: tag allocation, stall, qualified commit and restore flush.
*/
`timescale 1ns/1ps
`default_nettype none
`include "rename_defs.svh"

module renameControl import renamePkg::*; (
	input logic clk,
	input logic reset,
	input decodedInstr held,
	input logic robFull,
	input logic commitReq,
	input logic robEmpty,
	input logic restoreReq,
	output logic allocate,
	output logic stall,
	output logic commit,
	output logic flush
);

	logic needsTag; // Held instruction writes a real register.

	// ==================================================
	// Allocation and back-pressure
	// ==================================================
	assign needsTag = held.valid && held.regWrite && (held.rd != '0);

	// A restore drops the held instruction, so it must not claim a tag.
	assign allocate = needsTag && !robFull && !restoreReq;

	assign stall = needsTag && robFull; // Both stages freeze until a commit frees an entry.

	// ==================================================
	// Commit and restore
	// ==================================================
	assign commit = commitReq && !robEmpty; // Ignore commits with nothing in flight.
	assign flush = restoreReq; // Empties both stages and reloads the table and tail.

	// A stalled instruction gets no tag and is still waiting on the next cycle.
	assert property (@(posedge clk) disable iff (reset)
		stall && !restoreReq |-> !allocate ##1 held.valid)
		else $error("Stalled instruction was allocated or lost.");

endmodule

`default_nettype wire

// File: source/renamePkg.sv
/*
	Rename stage types: decoded and renamed instructions, operand tags,
	the status checkpoint and the commit record.
*/
`default_nettype none
`include "rename_defs.svh"

package renamePkg;

	// Instruction as it leaves decode.
	typedef struct packed {
		logic valid; // Slot holds an instruction.
		logic [`REG_W-1:0] rs1;
		logic [`REG_W-1:0] rs2;
		logic [`REG_W-1:0] rd; // Destination register.
		logic regWrite; // Instruction writes rd.
	} decodedInstr;

	// A clear busy bit means the operand comes from the register file.
	typedef struct packed {
		logic busy;
		logic [`ROB_W-1:0] robTag; // Producer entry, zero when not busy.
	} operandTag;

	typedef struct packed {
		logic valid;
		operandTag rs1Tag;
		operandTag rs2Tag;
		logic rdValid; // A ROB tag was given to rd.
		logic [`ROB_W-1:0] destTag;
	} renamedInstr;

	typedef struct packed {
		logic [`NUM_REGS-1:0] busyVector;
		logic [`ROB_W-1:0] robTail;
	} statusSnap;

	typedef struct packed {
		logic valid; // The head entry retires this cycle.
		logic [`ROB_W-1:0] robTag;
		logic [`REG_W-1:0] rd;
	} commitInfo;

endpackage

`default_nettype wire

// File: source/renameUnit.sv
/*
	Rename stage top level.
	Input register, status table, tag allocator, checkpoint and output register.
*/
`timescale 1ns/1ps
`default_nettype none
`include "rename_defs.svh"

module renameUnit import renamePkg::*; (
	input logic clk,
	input logic reset,
	input decodedInstr decodeIn,
	input logic commit,
	input logic takeSnap,
	input logic restoreSnap,
	output renamedInstr renamedOut,
	output logic renameStall,
	output logic robFull
);

	decodedInstr heldInstr; // Instruction being renamed this cycle.
	renamedInstr renamed;
	commitInfo commitRec;
	statusSnap savedSnap;
	logic [`NUM_REGS-1:0] busyVector;
	logic [`ROB_W-1:0] tailTag;
	logic allocate;
	logic stall;
	logic commitGo;
	logic flush;
	logic robEmpty;

	// ==================================================
	// Control
	// ==================================================
	renameControl i_renameControl (
		.clk(clk),
		.reset(reset),
		.held(heldInstr),
		.robFull(robFull),
		.commitReq(commit),
		.robEmpty(robEmpty),
		.restoreReq(restoreSnap),
		.allocate(allocate),
		.stall(stall),
		.commit(commitGo),
		.flush(flush)
	);

	// ==================================================
	// Datapath
	// ==================================================
	pipeStage #(.payloadT(decodedInstr)) instrStage (
		.clk(clk),
		.reset(reset),
		.hold(stall),
		.flush(flush),
		.d(decodeIn),
		.q(heldInstr)
	);

	regStatusTable i_regStatusTable (
		.clk(clk),
		.reset(reset),
		.instr(heldInstr),
		.allocate(allocate),
		.tailTag(tailTag),
		.commitIn(commitRec),
		.restore(flush),
		.restoreSnap(savedSnap),
		.renamed(renamed),
		.busyVector(busyVector)
	);

	// The stalled instruction stays in instrStage, so the last result is held here.
	pipeStage #(.payloadT(renamedInstr)) outStage (
		.clk(clk),
		.reset(reset),
		.hold(stall),
		.flush(flush),
		.d(renamed),
		.q(renamedOut)
	);

	robTagAllocator i_robTagAllocator (
		.clk(clk),
		.reset(reset),
		.allocate(allocate),
		.allocRd(heldInstr.rd),
		.commit(commitGo),
		.restore(flush),
		.restoreTail(savedSnap.robTail),
		.tailTag(tailTag),
		.commitOut(commitRec),
		.robFull(robFull),
		.robEmpty(robEmpty)
	);

	snapshotStore i_snapshotStore (
		.clk(clk),
		.reset(reset),
		.take(takeSnap),
		.busyVector(busyVector),
		.tail(tailTag),
		.saved(savedSnap)
	);

	assign renameStall = stall;

endmodule

`default_nettype wire

// File: source/rename_defs.svh
/*
	Rename stage sizing.
	Register file and ROB dimensions shared by the design and the testbench.
*/
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// ==================================================
// Architectural register file
// ==================================================
`define NUM_REGS 32 // Registers x0 to x31.
`define REG_W 5 // Bits in a register index.

// ==================================================
// Reorder buffer
// ==================================================
`define ROB_DEPTH 8 // Entries in flight at most.
`define ROB_W 3 // Bits in a ROB tag.

`endif

// File: source/robTagAllocator.sv
/*
	Circular ROB tag allocator.
	Hands out tail tags, records each entry's rd and retires entries from the head.
*/
`timescale 1ns/1ps
`default_nettype none
`include "rename_defs.svh"

module robTagAllocator import renamePkg::*; (
	input logic clk,
	input logic reset,
	input logic allocate,
	input logic [`REG_W-1:0] allocRd,
	input logic commit,
	input logic restore,
	input logic [`ROB_W-1:0] restoreTail,
	output logic [`ROB_W-1:0] tailTag,
	output commitInfo commitOut,
	output logic robFull,
	output logic robEmpty
);

	logic [`ROB_W-1:0] head; // Oldest in-flight entry.
	logic [`ROB_W-1:0] tail; // Next tag to hand out.
	logic [`ROB_W-1:0] headNext;
	logic [`ROB_W:0] count; // Needs one extra bit to tell full from empty.
	logic [`REG_W-1:0] robRd [`ROB_DEPTH]; // Destination of each entry.
	logic commitFire;

	assign robFull = (count == `ROB_DEPTH);
	assign robEmpty = (count == 0);
	assign commitFire = commit && !robEmpty; // Nothing retires from an empty ROB.
	assign headNext = commitFire ? head + 1'b1 : head;
	assign tailTag = tail;

	always_comb begin
		commitOut.valid = commitFire;
		commitOut.robTag = head;
		commitOut.rd = robRd[head];
	end

	// ==================================================
	// Pointers and occupancy
	// ==================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			head <= headNext; // Commits continue across a restore.
			if (restore) begin
				tail <= restoreTail;
				count <= {1'b0, restoreTail - headNext}; // Entries left after the rollback.
			end else begin
				if (allocate) begin
					tail <= tail + 1'b1; // Wraps around naturally.
				end
				count <= count + allocate - commitFire;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (allocate) begin
			robRd[tail] <= allocRd;
		end
	end

	// Control must stall a writer while the ROB is full.
	assert property (@(posedge clk) disable iff (reset) allocate |-> !robFull)
		else $error("Tag allocated while the ROB was full.");

	// A retiring entry must lie between the pointers, as the count claims.
	assert property (@(posedge clk) disable iff (reset)
		commitOut.valid |-> (head != tail) || robFull)
		else $error("Commit issued while the ROB pointers show it empty.");

endmodule

`default_nettype wire

// File: source/snapshotStore.sv
/*
	Single checkpoint of the busy vector and the ROB tail.
*/
`timescale 1ns/1ps
`default_nettype none
`include "rename_defs.svh"

module snapshotStore import renamePkg::*; (
	input logic clk,
	input logic reset,
	input logic take,
	input logic [`NUM_REGS-1:0] busyVector,
	input logic [`ROB_W-1:0] tail,
	output statusSnap saved
);

	// Both inputs are registered state, so a rename in the same cycle is not included.
	always_ff @(posedge clk) begin
		if (reset) begin
			saved <= '0; // Clean table, tail at zero.
		end else if (take) begin
			saved.busyVector <= busyVector;
			saved.robTail <= tail;
		end
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+source
source/renamePkg.sv
source/pipeStage.sv
source/regStatusTable.sv
source/robTagAllocator.sv
source/snapshotStore.sv
source/renameControl.sv
source/renameUnit.sv
verification/renameTb.sv

// File: verification/renameStim.txt
# name op rs1 rs2 rd regWrite | expected: rs1Busy rs1Tag rs2Busy rs2Tag rdValid destTag stall full
# Ops are rename, commit, snap, restore, status. Stall and full are checked only on status lines.
depWriteR5 rename 1 2 5 1 0 0 0 0 1 0 0 0
depReadR5 rename 5 0 6 1 1 0 0 0 1 1 0 0
depWriteX0 rename 6 5 0 1 1 1 1 0 0 0 0 0
depNop rename 0 0 0 0 0 0 0 0 0 0 0 0
depWriteR7 rename 7 5 7 1 0 0 1 0 1 2 0 0
bypassReadR5 rename 5 6 0 0 0 0 1 1 0 0 0 0
commitTag0 commit 0 0 0 0 0 0 0 0 0 0 0 0
rewriteR5 rename 5 0 5 1 0 0 0 0 1 3 0 0
commitTag1 commit 0 0 0 0 0 0 0 0 0 0 0 0
readFreedR6 rename 6 5 0 0 0 0 1 3 0 0 0 0
rewriteR7 rename 0 0 7 1 0 0 0 0 1 4 0 0
commitTag2 commit 0 0 0 0 0 0 0 0 0 0 0 0
readYoungR7 rename 7 7 0 0 1 4 1 4 0 0 0 0
chainA rename 5 7 10 1 1 3 1 4 1 5 0 0
chainB rename 10 0 11 1 1 5 0 0 1 6 0 0
chainC rename 11 10 12 1 1 6 1 5 1 7 0 0
commitTag3 commit 0 0 0 0 0 0 0 0 0 0 0 0
commitTag4 commit 0 0 0 0 0 0 0 0 0 0 0 0
commitTag5 commit 0 0 0 0 0 0 0 0 0 0 0 0
commitTag6 commit 0 0 0 0 0 0 0 0 0 0 0 0
commitTag7 commit 0 0 0 0 0 0 0 0 0 0 0 0
fillW1 rename 12 0 1 1 0 0 0 0 1 0 0 0
fillW2 rename 1 0 2 1 1 0 0 0 1 1 0 0
fillW3 rename 2 0 3 1 1 1 0 0 1 2 0 0
fillW4 rename 3 0 4 1 1 2 0 0 1 3 0 0
fillW5 rename 4 0 5 1 1 3 0 0 1 4 0 0
fillW6 rename 5 0 6 1 1 4 0 0 1 5 0 0
fillW7 rename 6 0 7 1 1 5 0 0 1 6 0 0
fillW8 rename 7 0 8 1 1 6 0 0 1 7 0 0
heldW9 rename 1 8 9 1 0 0 1 7 1 0 0 0
fullStall status 0 0 0 0 0 0 0 0 0 0 1 1
commitFill0 commit 0 0 0 0 0 0 0 0 0 0 0 0
resumeStatus status 0 0 0 0 0 0 0 0 0 0 0 0
refullStatus status 0 0 0 0 0 0 0 0 0 0 0 1
commitFill1 commit 0 0 0 0 0 0 0 0 0 0 0 0
commitFill2 commit 0 0 0 0 0 0 0 0 0 0 0 0
takeCheckpoint snap 0 0 0 0 0 0 0 0 0 0 0 0
specWriteA rename 4 9 20 1 1 3 1 0 1 1 0 0
specWriteB rename 20 0 21 1 1 1 0 0 1 2 0 0
rollBack restore 0 0 0 0 0 0 0 0 0 0 0 0
readAfterRestore rename 20 21 0 0 0 0 0 0 0 0 0 0
writeAfterRestore rename 4 0 22 1 1 3 0 0 1 1 0 0
finalStatus status 0 0 0 0 0 0 0 0 0 0 0 0

// File: verification/renameTb.sv
/*
	Rename stage testbench.
	Replays a stimulus file and checks every renamed result, its latency and the stall flags.
*/
`timescale 1ns/1ps
`default_nettype none
`include "rename_defs.svh"

module renameTb import renamePkg::*; ();

	logic clk;
	logic reset;
	decodedInstr decodeIn;
	logic commit;
	logic takeSnap;
	logic restoreSnap;
	renamedInstr renamedOut;
	logic renameStall;
	logic robFull;

	renamedInstr expQ [$]; // Expected results in issue order.
	string nameQ [$];
	int issueQ [$]; // Cycle in which each instruction was driven.
	int stallAtQ [$]; // Stall total when it was driven.
	int cycle; // Counts falling edges after reset.
	int stallTotal; // Cycles that renameStall was high.
	logic prevStall; // Stall seen before the last rising edge.

	renameUnit i_renameUnit (
		.clk(clk),
		.reset(reset),
		.decodeIn(decodeIn),
		.commit(commit),
		.takeSnap(takeSnap),
		.restoreSnap(restoreSnap),
		.renamedOut(renamedOut),
		.renameStall(renameStall),
		.robFull(robFull)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period.
	end

	// ==================================================
	// Reporting and compare tasks
	// ==================================================
	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "Stopping at the first error.");
	endtask

	task automatic checkRenamed(input string name, input renamedInstr expected,
			input renamedInstr actual);
		if (actual !== expected) begin
			failRun($sformatf("Fail %s renamedOut: expected %h, actual %h",
				name, expected, actual));
		end
	endtask

	// The two flags are compared together as {renameStall, robFull}.
	task automatic checkStall(input string name, input logic [1:0] expected,
			input logic [1:0] actual);
		if (actual !== expected) begin
			failRun($sformatf("Fail %s stall/full: expected %b, actual %b",
				name, expected, actual));
		end
	endtask

	task automatic checkLatency(input string name, input int expected, input int actual);
		if (actual != expected) begin
			failRun($sformatf("Fail %s arrival cycle: expected %0d, actual %0d",
				name, expected, actual));
		end
	endtask

	// ==================================================
	// Cycle driver and output monitor
	// ==================================================
	// A held outStage repeats its result, so only a result loaded without stall is new.
	task automatic monitorOutputs();
		int expectedCycle;
		cycle++;
		if (renamedOut.valid && !prevStall) begin
			if (expQ.size() == 0) begin
				failRun("A result appeared on renamedOut with nothing in flight.");
			end else begin
				expectedCycle = issueQ[0] + 2 + (stallTotal - stallAtQ[0]); // Two cycles plus stalls.
				checkRenamed(nameQ[0], expQ[0], renamedOut);
				checkLatency(nameQ[0], expectedCycle, cycle);
				void'(expQ.pop_front());
				void'(nameQ.pop_front());
				void'(issueQ.pop_front());
				void'(stallAtQ.pop_front());
			end
		end
	endtask

	task automatic step(input decodedInstr instr, input logic doCommit, input logic doSnap,
			input logic doRestore, input bit issued, input string name,
			input renamedInstr expected);
		@(posedge clk);
		decodeIn <= instr;
		commit <= doCommit;
		takeSnap <= doSnap;
		restoreSnap <= doRestore;
		@(negedge clk);
		monitorOutputs(); // Outputs are settled half a cycle after the edge.
		if (issued) begin
			expQ.push_back(expected);
			nameQ.push_back(name);
			issueQ.push_back(cycle);
			stallAtQ.push_back(stallTotal);
		end
		stallTotal += renameStall;
		prevStall = renameStall;
	endtask

	task automatic idleStep();
		step('0, 1'b0, 1'b0, 1'b0, 1'b0, "", '0);
	endtask

	// decodeIn is ignored during a stall, so a new instruction waits for it to clear.
	task automatic waitStallLow();
		int count;
		count = 0;
		while (renameStall) begin
			if (count == 20) begin
				failRun("Timed out waiting for renameStall to fall.");
			end
			idleStep();
			count++;
		end
	endtask

	task automatic drainOutputs();
		int count;
		count = 0;
		while (expQ.size() > 0) begin
			if (count == 20) begin
				failRun("Timed out waiting for a valid result on renamedOut.");
			end
			idleStep();
			count++;
		end
	endtask

	// ==================================================
	// Stimulus file replay
	// ==================================================
	initial begin
		int fd;
		int code;
		int n;
		int rs1, rs2, rd, rw;
		int b1, t1, b2, t2, rdv, dt, st, fl;
		string line;
		string name;
		string op;
		decodedInstr instr;
		renamedInstr expected;
		reset = 1'b1;
		decodeIn = '0;
		commit = 1'b0;
		takeSnap = 1'b0;
		restoreSnap = 1'b0;
		cycle = 0;
		stallTotal = 0;
		prevStall = 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		fd = $fopen("verification/renameStim.txt", "r");
		if (fd == 0) begin
			failRun("Could not open the stimulus file.");
		end
		while (!$feof(fd)) begin
			line = "";
			code = $fgets(line, fd);
			if (code > 0 && line.len() > 1 && line[0] != "#") begin
				n = $sscanf(line, "%s %s %d %d %d %d %d %d %d %d %d %d %d %d", name, op,
					rs1, rs2, rd, rw, b1, t1, b2, t2, rdv, dt, st, fl);
				if (n != 14) begin
					failRun($sformatf("Malformed stimulus line: %s", line));
				end
				instr.valid = 1'b1;
				instr.rs1 = rs1[`REG_W-1:0];
				instr.rs2 = rs2[`REG_W-1:0];
				instr.rd = rd[`REG_W-1:0];
				instr.regWrite = rw[0];
				expected.valid = 1'b1;
				expected.rs1Tag.busy = b1[0];
				expected.rs1Tag.robTag = t1[`ROB_W-1:0];
				expected.rs2Tag.busy = b2[0];
				expected.rs2Tag.robTag = t2[`ROB_W-1:0];
				expected.rdValid = rdv[0];
				expected.destTag = dt[`ROB_W-1:0];
				if (op == "rename") begin
					waitStallLow();
					step(instr, 1'b0, 1'b0, 1'b0, 1'b1, name, expected);
				end else if (op == "commit") begin
					step('0, 1'b1, 1'b0, 1'b0, 1'b0, name, '0);
				end else if (op == "snap") begin
					drainOutputs(); // Checkpoint a settled table.
					step('0, 1'b0, 1'b1, 1'b0, 1'b0, name, '0);
				end else if (op == "restore") begin
					drainOutputs();
					step('0, 1'b0, 1'b0, 1'b1, 1'b0, name, '0);
				end else if (op == "status") begin
					idleStep();
					checkStall(name, {st[0], fl[0]}, {renameStall, robFull});
				end else begin
					failRun($sformatf("Unknown operation %s in the stimulus file.", op));
				end
			end
		end
		$fclose(fd);
		drainOutputs();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire
